/* rtl/isa_pkg.sv */
// ISA-level widths, privilege encoding and instruction size, imported by RTL and testbench
package isa_pkg;

    // ------------------------------
    // Address widths
    // ------------------------------
    localparam int unsigned VLEN = 39;  // Sv39 virtual address

    typedef logic [VLEN-1:0] vaddr_t;   // PCs and restart addresses

    // Step from the committed PC to the instruction after it
    localparam int unsigned INSTR_BYTES = 4;

    // ------------------------------
    // Privilege levels
    // ------------------------------
    // Two-bit ISA encoding, 2'b10 is reserved
    typedef enum logic [1:0] {
        PRIV_U = 2'b00,
        PRIV_S = 2'b01,
        PRIV_M = 2'b11
    } priv_lvl_e;

endpackage

/* rtl/flush_pkg.sv */
// Flush controller constants, counter widths and fence.t state encoding, imported by the RTL
package flush_pkg;

    // ------------------------------
    // Feature switches
    // ------------------------------
    localparam bit RVH_EN    = 1'b1;  // Hypervisor fences present
    localparam bit DCACHE_WB = 1'b1;  // Write-back dcache, fence and fence.i must flush it

    // ------------------------------
    // Counter widths
    // ------------------------------
    typedef logic [31:0] pad_cnt_t;   // Pad value, pad count and ceiling
    typedef logic [3:0]  drain_cnt_t; // Idle cycles seen since the last busy cycle

    // ------------------------------
    // Timing
    // ------------------------------
    localparam int unsigned DRAIN_IDLE_CYCLES = 16; // Quiet cycles before the drain ends
    localparam int unsigned RST_UARCH_CYCLES  = 16; // Length of the micro-reset pulse
    localparam int unsigned CACHE_INIT_HOLD   = 3;  // Extra cycles that block cache init

    // fence.t sequence, one state per step
    typedef enum logic [2:0] {
        FT_IDLE,
        FT_FLUSH_DCACHE,  // Wait for the dcache flush ack
        FT_DRAIN,         // Wait for cache traffic to go quiet
        FT_PAD,           // Wait for the pad count to run out
        FT_RST_UARCH      // Micro-architectural reset
    } fence_t_state_e;

endpackage

/* rtl/updown_counter.sv */
// Loadable, clearable up/down counter; instantiated for the fence.t drain and pad counts
`timescale 1ns/1ps

module updown_counter #(
    parameter int unsigned WIDTH = 4
) (
    input  logic             clk_i,
    input  logic             rst_ni,
    input  logic             clear_i,  // Highest priority
    input  logic             en_i,     // Count enable, lowest priority
    input  logic             load_i,
    input  logic             down_i,   // 1 counts down, 0 counts up
    input  logic [WIDTH-1:0] d_i,      // Load value
    output logic [WIDTH-1:0] q_o
);

    logic [WIDTH-1:0] cnt_d, cnt_q;

    always_comb begin
        cnt_d = cnt_q;
        if (clear_i) begin
            cnt_d = '0;
        end else if (load_i) begin
            cnt_d = d_i;
        end else if (en_i) begin
            cnt_d = down_i ? cnt_q - 1'b1 : cnt_q + 1'b1;  // Wraps silently
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            cnt_q <= '0;
        end else begin
            cnt_q <= cnt_d;
        end
    end

    assign q_o = cnt_q;

endmodule

/* rtl/flush_decode.sv */
// Decodes pipeline events into per-stage flush strobes, holds the restart address and fence state
`timescale 1ns/1ps

module flush_decode (
    input  logic           clk_i,
    input  logic           rst_ni,
    // Event strobes
    input  logic           mispredict_i,
    input  logic           fence_i,
    input  logic           fence_i_i,
    input  logic           sfence_vma_i,
    input  logic           hfence_vvma_i,
    input  logic           hfence_gvma_i,
    input  logic           fence_t_i,
    input  logic           flush_csr_i,     // CSR write with side effects
    input  logic           flush_commit_i,
    input  logic           ex_valid_i,
    input  logic           eret_i,
    input  logic           set_debug_pc_i,
    input  logic           v_i,             // Virtualization on
    input  logic           flush_dcache_ack_i,
    input  isa_pkg::vaddr_t pc_commit_i,
    input  isa_pkg::vaddr_t boot_addr_i,
    // Flush strobes
    output logic           set_pc_commit_o,
    output logic           flush_if_o,
    output logic           flush_unissued_o,
    output logic           flush_id_o,
    output logic           flush_ex_o,
    output logic           flush_bp_o,
    output logic           flush_icache_o,
    output logic           flush_tlb_o,
    output logic           flush_tlb_vvma_o,
    output logic           flush_tlb_gvma_o,
    // Dcache flush and restart address
    output logic           dcache_req_o,
    output logic           fence_active_o,
    output isa_pkg::vaddr_t rst_addr_o
);

    import isa_pkg::*;
    import flush_pkg::*;

    logic   hfence_vvma, hfence_gvma;  // Hypervisor fences, gone without RVH
    logic   guest_sfence;              // sfence.vma issued from a guest
    logic   pipe_flush;                // Events that restart from the commit PC
    logic   trap;                      // Exception, eret or debug entry
    logic   fence_set;                 // Events that start a dcache flush
    logic   fence_active_d, fence_active_q;
    logic   rst_addr_vld_q;            // Restart address saved by a fence.t
    vaddr_t rst_addr_q;

    // ------------------------------
    // Flush rule table
    // ------------------------------
    assign hfence_vvma  = RVH_EN && hfence_vvma_i;
    assign hfence_gvma  = RVH_EN && hfence_gvma_i;
    assign guest_sfence = RVH_EN && v_i;

    assign pipe_flush = fence_i | fence_i_i | sfence_vma_i | hfence_vvma | hfence_gvma
                      | flush_csr_i | flush_commit_i;
    assign trap       = ex_valid_i | eret_i | set_debug_pc_i;

    // A trap takes its own target PC, so it overrides the commit restart
    assign set_pc_commit_o  = pipe_flush & ~trap;
    assign flush_if_o       = mispredict_i | pipe_flush | trap;
    assign flush_unissued_o = mispredict_i | pipe_flush | trap;
    assign flush_id_o       = pipe_flush | trap;
    assign flush_ex_o       = pipe_flush | trap;
    assign flush_bp_o       = trap;  // Drop speculative state on privilege change
    assign flush_icache_o   = fence_i_i | fence_t_i;

    // TLB select: guest translations go to the VS-stage flush
    assign flush_tlb_o      = sfence_vma_i & ~guest_sfence;
    assign flush_tlb_vvma_o = (sfence_vma_i & guest_sfence) | hfence_vvma;
    assign flush_tlb_gvma_o = hfence_gvma;

    // ------------------------------
    // Dcache flush handshake
    // ------------------------------
    assign fence_set = fence_t_i | (DCACHE_WB && (fence_i | fence_i_i));

    always_comb begin
        fence_active_d = fence_active_q;
        if (fence_active_q && flush_dcache_ack_i) begin
            fence_active_d = 1'b0;  // Flush done
        end
        if (fence_set) begin
            fence_active_d = 1'b1;
        end
    end

    // Request held from the starting strobe until the ack
    assign dcache_req_o   = fence_set | (fence_active_q & ~flush_dcache_ack_i);
    assign fence_active_o = fence_active_q;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            fence_active_q <= 1'b0;
            rst_addr_vld_q <= 1'b0;
        end else begin
            fence_active_q <= fence_active_d;
            if (fence_t_i) rst_addr_vld_q <= 1'b1;
        end
    end

    // Restart after the micro-reset at the instruction behind the fence.t
    always_ff @(posedge clk_i) begin
        if (fence_t_i) rst_addr_q <= pc_commit_i + vaddr_t'(INSTR_BYTES);
    end

    assign rst_addr_o = rst_addr_vld_q ? rst_addr_q : boot_addr_i;

endmodule

/* rtl/fence_t_seq.sv */
// fence.t sequencer: dcache flush wait, drain, pad to a reference point and micro-reset
`timescale 1ns/1ps

module fence_t_seq (
    input  logic               clk_i,
    input  logic               rst_ni,
    input  logic               fence_t_i,
    input  logic               flush_dcache_ack_i,
    input  logic               cache_busy_i,
    input  logic               time_irq_i,
    input  isa_pkg::priv_lvl_e priv_lvl_i,
    input  logic               fence_t_src_sel_i,  // 0 time irq, 1 exit from U-mode
    input  flush_pkg::pad_cnt_t fence_t_pad_i,
    output logic               seq_busy_o,
    output logic               rst_uarch_no,
    output logic               init_req_o,
    output flush_pkg::pad_cnt_t fence_t_ceil_o
);

    import isa_pkg::*;
    import flush_pkg::*;

    localparam int unsigned RstCntW = $clog2(RST_UARCH_CYCLES);

    fence_t_state_e     state_d, state_q;
    logic [RstCntW-1:0] rst_cnt_d, rst_cnt_q;  // Micro-reset timer
    drain_cnt_t         drain_cnt;
    logic               drain_done;
    pad_cnt_t           pad_cnt;
    logic               load_pad;
    logic               time_irq_q;
    priv_lvl_e          priv_lvl_q;

    // ------------------------------
    // Pad start and counters
    // ------------------------------
    // Start on a timer edge or on leaving U-mode
    assign load_pad = fence_t_src_sel_i ? ((priv_lvl_q == PRIV_U) && (priv_lvl_i != PRIV_U))
                                        : (time_irq_i && !time_irq_q);

    assign drain_done = (drain_cnt == drain_cnt_t'(DRAIN_IDLE_CYCLES - 1));

    // Counts quiet cycles, restarts on every busy cycle
    updown_counter #(
        .WIDTH ($bits(drain_cnt_t))
    ) i_drain_cnt (
        .clk_i   (clk_i),
        .rst_ni  (rst_ni),
        .clear_i (cache_busy_i),
        .en_i    (!drain_done),  // Saturate
        .load_i  (1'b0),
        .down_i  (1'b0),
        .d_i     ('0),
        .q_o     (drain_cnt)
    );

    updown_counter #(
        .WIDTH ($bits(pad_cnt_t))
    ) i_pad_cnt (
        .clk_i   (clk_i),
        .rst_ni  (rst_ni),
        .clear_i (1'b0),
        .en_i    (|pad_cnt),      // Down to zero, then hold
        .load_i  (load_pad),
        .down_i  (1'b1),
        .d_i     (fence_t_pad_i),
        .q_o     (pad_cnt)
    );

    // ------------------------------
    // State machine
    // ------------------------------
    always_comb begin
        state_d        = state_q;
        rst_cnt_d      = rst_cnt_q;
        rst_uarch_no   = 1'b1;
        fence_t_ceil_o = '0;
        unique case (state_q)
            FT_IDLE: begin
                if (fence_t_i) state_d = FT_FLUSH_DCACHE;
            end
            FT_FLUSH_DCACHE: begin
                if (flush_dcache_ack_i) state_d = FT_DRAIN;
            end
            FT_DRAIN: begin
                if (drain_done) begin
                    state_d        = FT_PAD;
                    // Cycles elapsed since the pad load, zero once it ran out
                    fence_t_ceil_o = (pad_cnt == '0) ? '0 : fence_t_pad_i - pad_cnt;
                end
            end
            FT_PAD: begin
                if (pad_cnt == '0) state_d = FT_RST_UARCH;
            end
            FT_RST_UARCH: begin
                rst_uarch_no = 1'b0;
                rst_cnt_d    = rst_cnt_q + 1'b1;  // Wraps to zero on the last cycle
                if (rst_cnt_q == RstCntW'(RST_UARCH_CYCLES - 1)) state_d = FT_IDLE;
            end
            default: state_d = FT_IDLE;
        endcase
    end

    assign seq_busy_o = (state_q != FT_IDLE);
    assign init_req_o = (state_q == FT_RST_UARCH);  // Cache init held off from here

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q    <= FT_IDLE;
            rst_cnt_q  <= '0;
            time_irq_q <= 1'b0;
            priv_lvl_q <= PRIV_M;
        end else begin
            state_q    <= state_d;
            rst_cnt_q  <= rst_cnt_d;
            time_irq_q <= time_irq_i;
            priv_lvl_q <= priv_lvl_i;
        end
    end

endmodule

/* rtl/ctrl_merge.sv */
// Merges decoder and sequencer results into the dcache flush, halt, stall and cache-init outputs
`timescale 1ns/1ps

module ctrl_merge (
    input  logic clk_i,
    input  logic rst_ni,
    input  logic dcache_req_i,    // From the decoder, held until ack
    input  logic fence_active_i,
    input  logic seq_busy_i,      // fence.t in progress
    input  logic init_req_i,      // Micro-reset active
    input  logic halt_csr_i,      // WFI and the like
    output logic flush_dcache_o,
    output logic halt_o,
    output logic stall_cache_o,
    output logic cache_init_no
);

    import flush_pkg::*;

    logic [CACHE_INIT_HOLD-1:0] init_sr_q;  // Stretches the micro-reset for the caches

    // ------------------------------
    // Core-facing levels
    // ------------------------------
    assign halt_o        = halt_csr_i | fence_active_i | seq_busy_i;
    assign stall_cache_o = seq_busy_i;  // No new cache requests during fence.t
    assign cache_init_no = |init_sr_q;

    // Flush request is timing critical toward the cache, so it is registered
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            flush_dcache_o <= 1'b0;
            init_sr_q      <= '0;
        end else begin
            flush_dcache_o <= dcache_req_i;
            init_sr_q      <= {init_sr_q[CACHE_INIT_HOLD-2:0], init_req_i};
        end
    end

endmodule

/* rtl/flush_ctrl_top.sv */
// Flush and fence controller top level; connects the event decoder, fence.t sequencer and merge
`timescale 1ns/1ps

module flush_ctrl_top (
    input  logic                clk_i,
    input  logic                rst_ni,
    // Pipeline events
    input  logic                mispredict_i,
    input  logic                fence_i,
    input  logic                fence_i_i,
    input  logic                sfence_vma_i,
    input  logic                hfence_vvma_i,
    input  logic                hfence_gvma_i,
    input  logic                fence_t_i,
    input  logic                flush_csr_i,
    input  logic                flush_commit_i,
    input  logic                ex_valid_i,
    input  logic                eret_i,
    input  logic                set_debug_pc_i,
    input  logic                v_i,
    input  logic                halt_csr_i,
    // Cache side
    input  logic                flush_dcache_ack_i,
    input  logic                cache_busy_i,
    // fence.t reference point
    input  logic                time_irq_i,
    input  isa_pkg::priv_lvl_e  priv_lvl_i,
    input  flush_pkg::pad_cnt_t fence_t_pad_i,
    input  logic                fence_t_src_sel_i,
    input  isa_pkg::vaddr_t     pc_commit_i,
    input  isa_pkg::vaddr_t     boot_addr_i,
    // Flush strobes
    output logic                set_pc_commit_o,
    output logic                flush_if_o,
    output logic                flush_unissued_o,
    output logic                flush_id_o,
    output logic                flush_ex_o,
    output logic                flush_bp_o,
    output logic                flush_icache_o,
    output logic                flush_dcache_o,
    output logic                flush_tlb_o,
    output logic                flush_tlb_vvma_o,
    output logic                flush_tlb_gvma_o,
    // Control
    output logic                halt_o,
    output logic                stall_cache_o,
    output logic                cache_init_no,
    output logic                rst_uarch_no,
    output flush_pkg::pad_cnt_t fence_t_ceil_o,
    output isa_pkg::vaddr_t     rst_addr_o
);

    logic dcache_req;
    logic fence_active;
    logic seq_busy;
    logic init_req;

    flush_decode i_flush_decode (
        .clk_i              (clk_i),
        .rst_ni             (rst_ni),
        .mispredict_i       (mispredict_i),
        .fence_i            (fence_i),
        .fence_i_i          (fence_i_i),
        .sfence_vma_i       (sfence_vma_i),
        .hfence_vvma_i      (hfence_vvma_i),
        .hfence_gvma_i      (hfence_gvma_i),
        .fence_t_i          (fence_t_i),
        .flush_csr_i        (flush_csr_i),
        .flush_commit_i     (flush_commit_i),
        .ex_valid_i         (ex_valid_i),
        .eret_i             (eret_i),
        .set_debug_pc_i     (set_debug_pc_i),
        .v_i                (v_i),
        .flush_dcache_ack_i (flush_dcache_ack_i),
        .pc_commit_i        (pc_commit_i),
        .boot_addr_i        (boot_addr_i),
        .set_pc_commit_o    (set_pc_commit_o),
        .flush_if_o         (flush_if_o),
        .flush_unissued_o   (flush_unissued_o),
        .flush_id_o         (flush_id_o),
        .flush_ex_o         (flush_ex_o),
        .flush_bp_o         (flush_bp_o),
        .flush_icache_o     (flush_icache_o),
        .flush_tlb_o        (flush_tlb_o),
        .flush_tlb_vvma_o   (flush_tlb_vvma_o),
        .flush_tlb_gvma_o   (flush_tlb_gvma_o),
        .dcache_req_o       (dcache_req),
        .fence_active_o     (fence_active),
        .rst_addr_o         (rst_addr_o)
    );

    fence_t_seq i_fence_t_seq (
        .clk_i              (clk_i),
        .rst_ni             (rst_ni),
        .fence_t_i          (fence_t_i),
        .flush_dcache_ack_i (flush_dcache_ack_i),
        .cache_busy_i       (cache_busy_i),
        .time_irq_i         (time_irq_i),
        .priv_lvl_i         (priv_lvl_i),
        .fence_t_src_sel_i  (fence_t_src_sel_i),
        .fence_t_pad_i      (fence_t_pad_i),
        .seq_busy_o         (seq_busy),
        .rst_uarch_no       (rst_uarch_no),
        .init_req_o         (init_req),
        .fence_t_ceil_o     (fence_t_ceil_o)
    );

    ctrl_merge i_ctrl_merge (
        .clk_i          (clk_i),
        .rst_ni         (rst_ni),
        .dcache_req_i   (dcache_req),
        .fence_active_i (fence_active),
        .seq_busy_i     (seq_busy),
        .init_req_i     (init_req),
        .halt_csr_i     (halt_csr_i),
        .flush_dcache_o (flush_dcache_o),
        .halt_o         (halt_o),
        .stall_cache_o  (stall_cache_o),
        .cache_init_no  (cache_init_no)
    );

endmodule

/* dv/flush_ctrl_assertions.sv */
// Concurrent checks on halt, stall and micro-reset relations, bound into the flush controller top
`timescale 1ns/1ps

module flush_ctrl_assertions (
    input  logic                clk_i,
    input  logic                rst_ni,
    input  logic                halt_o,
    input  logic                stall_cache_o,
    input  logic                rst_uarch_no,
    input  flush_pkg::pad_cnt_t fence_t_ceil_o
);

    // Micro-reset only happens inside a fence.t
    rst_in_stall: assert property (@(posedge clk_i) disable iff (!rst_ni)
        !rst_uarch_no |-> stall_cache_o)
        else $error("micro-reset active without cache stall");

    // A stalled cache always halts the core
    stall_halts: assert property (@(posedge clk_i) disable iff (!rst_ni)
        stall_cache_o |-> halt_o)
        else $error("cache stall without halt");

    // Ceiling only shows at drain end, never during the micro-reset
    ceil_window: assert property (@(posedge clk_i) disable iff (!rst_ni)
        (fence_t_ceil_o != '0) |-> (stall_cache_o && rst_uarch_no))
        else $error("pad ceiling outside the drain end");

endmodule

bind flush_ctrl_top flush_ctrl_assertions u_flush_ctrl_assertions (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .halt_o         (halt_o),
    .stall_cache_o  (stall_cache_o),
    .rst_uarch_no   (rst_uarch_no),
    .fence_t_ceil_o (fence_t_ceil_o)
);

/* dv/flush_ctrl_tb.sv */
// Testbench for the flush controller: event table, dcache handshake and fence.t scenarios
`timescale 1ns/1ps

module flush_ctrl_tb;

    import isa_pkg::*;
    import flush_pkg::*;

    localparam int PAD         = 40;  // Pad value for fence.t runs
    localparam int BUSY_END    = 12;  // Last random busy cycle in a fence.t run
    localparam int TEST_CYCLES = 4 + 14 * 40 + 20 + 3 * (PAD + 40);

    // Event bits: v, mispredict, fence, fence.i, sfence, hvvma, hgvma, fence.t,
    // csr, commit, ex, eret, debug
    localparam logic [12:0] STIM [14] = '{
        13'b0100000000000, 13'b0010000000000, 13'b0001000000000, 13'b0000100000000,
        13'b1000100000000, 13'b0000010000000, 13'b0000001000000, 13'b0000000100000,
        13'b0000000010000, 13'b0000000001000, 13'b0000000000100, 13'b0000000000010,
        13'b0000000000001, 13'b0000000001100};
    // Expected: set_pc, if, unissued, id, ex, bp, icache, tlb, vvma, gvma
    localparam logic [9:0] EXP [14] = '{
        10'b0110000000, 10'b1111100000, 10'b1111101000, 10'b1111100100,
        10'b1111100010, 10'b1111100010, 10'b1111100001, 10'b0000001000,
        10'b1111100000, 10'b1111100000, 10'b0111110000, 10'b0111110000,
        10'b0111110000, 10'b0111110000};

    logic clk_i = 1'b0;
    logic rst_ni;
    logic mispredict_i, fence_i, fence_i_i, sfence_vma_i, hfence_vvma_i, hfence_gvma_i;
    logic fence_t_i, flush_csr_i, flush_commit_i, ex_valid_i, eret_i, set_debug_pc_i;
    logic v_i, halt_csr_i, flush_dcache_ack_i, cache_busy_i, time_irq_i, fence_t_src_sel_i;
    priv_lvl_e priv_lvl_i;
    pad_cnt_t  fence_t_pad_i, fence_t_ceil_o;
    vaddr_t    pc_commit_i, boot_addr_i, rst_addr_o;
    logic set_pc_commit_o, flush_if_o, flush_unissued_o, flush_id_o, flush_ex_o, flush_bp_o;
    logic flush_icache_o, flush_dcache_o, flush_tlb_o, flush_tlb_vvma_o, flush_tlb_gvma_o;
    logic halt_o, stall_cache_o, cache_init_no, rst_uarch_no;
    int   checks = 0;
    int   errors = 0;

    flush_ctrl_top uut (.*);

    always #50 clk_i = ~clk_i;  // 100 ns period

    // ------------------------------
    // Helpers
    // ------------------------------
    task automatic next_cycle();
        @(posedge clk_i);
        #1;  // Inputs change just after the edge
    endtask

    task automatic check(input bit ok, input string msg);
        checks++;
        assert (ok) else begin
            $display("[FAIL] %0t ns: %s", $time, msg);
            errors++;
        end
    endtask

    task automatic report(input string name, input int err_before);
        $display("test %-24s %s", name, (errors == err_before) ? "ok" : "had errors");
    endtask

    task automatic drive_events(input logic [12:0] s);
        {v_i, mispredict_i, fence_i, fence_i_i, sfence_vma_i, hfence_vvma_i, hfence_gvma_i,
         fence_t_i, flush_csr_i, flush_commit_i, ex_valid_i, eret_i, set_debug_pc_i} = s;
    endtask

    // One fence.t run; trigger at cycle 2 is a priv drop or a time-irq edge
    task automatic run_fence_t(input bit src_sel, input bit by_priv, input bit expect_pad);
        int c, d_exp, ceil_cyc, ceil_val, rst_first, rst_last, rst_cnt;
        int init_first, init_last, stall_cnt, stall_last;
        vaddr_t pc;
        c = 0;
        ceil_cyc = -1;
        ceil_val = 0;
        rst_first = -1;
        rst_last = -1;
        rst_cnt = 0;
        init_first = -1;
        init_last = -1;
        stall_cnt = 0;
        stall_last = -1;
        d_exp = BUSY_END + 16;  // Drain counter reaches 15 here
        pc = vaddr_t'({$urandom(), $urandom()});
        next_cycle();
        fence_t_src_sel_i = src_sel;
        priv_lvl_i = by_priv ? PRIV_U : PRIV_M;
        fence_t_i = 1'b1;
        pc_commit_i = pc;
        cache_busy_i = 1'b1;  // Restarts the quiet count together with the strobe
        while (!(rst_cnt > 0 && !cache_init_no && !stall_cache_o)) begin
            next_cycle();
            c++;
            fence_t_i = 1'b0;
            flush_dcache_ack_i = (c == 1);
            if (c == 2) begin
                if (by_priv) priv_lvl_i = PRIV_M;
                else time_irq_i = 1'b1;
            end
            cache_busy_i = (c == BUSY_END) ? 1'b1 : (c < BUSY_END) ? 1'($urandom() % 2) : 1'b0;
            @(negedge clk_i);
            if (c == 1) check(rst_addr_o == pc + vaddr_t'(4), "restart address after fence.t");
            if (fence_t_ceil_o != '0 && ceil_cyc < 0) begin
                ceil_cyc = c;
                ceil_val = int'(fence_t_ceil_o);
            end
            if (!rst_uarch_no) begin
                if (rst_first < 0) rst_first = c;
                rst_last = c;
                rst_cnt++;
            end
            if (cache_init_no) begin
                if (init_first < 0) init_first = c;
                init_last = c;
            end
            if (stall_cache_o) begin
                stall_cnt++;
                stall_last = c;
            end
        end
        time_irq_i = 1'b0;
        if (expect_pad) begin
            check(ceil_cyc == d_exp, "ceiling not at drain end");
            check(ceil_val == d_exp - 3, "ceiling differs from cycles since pad load");
            check(rst_first == PAD + 4, "micro-reset start after pad");
        end else begin
            check(ceil_cyc < 0, "nonzero ceiling without pad load");
            check(rst_first == d_exp + 2, "micro-reset not right after drain");
        end
        check(rst_cnt == 16 && rst_last == rst_first + 15, "micro-reset length");
        check(init_first == rst_first + 1, "cache init hold start");
        check(init_last == rst_last + 3, "cache init hold end");
        check(stall_cnt == rst_last && stall_last == rst_last, "cache stall window");
    endtask

    // ------------------------------
    // Watchdog
    // ------------------------------
    initial begin
        #((TEST_CYCLES + 500) * 100);
        $display("Watchdog timeout: the run did not finish in time");
        $display("CHECKS FAILED");
        $finish;
    end

    // ------------------------------
    // Main sequence
    // ------------------------------
    initial begin
        int e, d;
        void'($urandom(46796));
        rst_ni = 1'b0;
        drive_events('0);
        halt_csr_i = 1'b0;
        flush_dcache_ack_i = 1'b0;
        cache_busy_i = 1'b0;
        time_irq_i = 1'b0;
        fence_t_src_sel_i = 1'b0;
        priv_lvl_i = PRIV_M;
        fence_t_pad_i = pad_cnt_t'(PAD);
        pc_commit_i = vaddr_t'({$urandom(), $urandom()});
        boot_addr_i = vaddr_t'({$urandom(), $urandom()});
        repeat (4) @(posedge clk_i);
        #1 rst_ni = 1'b1;

        e = errors;  // Reset values
        @(negedge clk_i);
        check({set_pc_commit_o, flush_if_o, flush_unissued_o, flush_id_o, flush_ex_o,
               flush_bp_o, flush_icache_o, flush_dcache_o, flush_tlb_o, flush_tlb_vvma_o,
               flush_tlb_gvma_o, halt_o, stall_cache_o, cache_init_no} == '0,
              "outputs not idle after reset");
        check(rst_uarch_no && rst_addr_o == boot_addr_i, "reset address or micro-reset");
        report("reset", e);

        e = errors;  // Event table
        for (int i = 0; i < 14; i++) begin
            next_cycle();
            drive_events(STIM[i]);
            @(negedge clk_i);
            check({set_pc_commit_o, flush_if_o, flush_unissued_o, flush_id_o, flush_ex_o,
                   flush_bp_o, flush_icache_o, flush_tlb_o, flush_tlb_vvma_o,
                   flush_tlb_gvma_o} == EXP[i], $sformatf("flush strobes for row %0d", i));
            next_cycle();
            drive_events('0);
            flush_dcache_ack_i = 1'b1;
            next_cycle();
            flush_dcache_ack_i = 1'b0;
            while (halt_o) next_cycle();
        end
        report("event table", e);

        e = errors;  // Fence with random ack delay
        next_cycle();
        fence_i = 1'b1;
        d = 1 + int'($urandom() % 5);
        for (int c = 1; c <= d + 2; c++) begin
            next_cycle();
            fence_i = 1'b0;
            flush_dcache_ack_i = (c == d + 1);
            @(negedge clk_i);
            check(flush_dcache_o == (c <= d + 1), "dcache flush request level");
            check(halt_o == (c <= d + 1), "halt during dcache flush");
        end
        flush_dcache_ack_i = 1'b0;
        report("fence dcache flush", e);

        e = errors;
        run_fence_t(1'b0, 1'b0, 1'b1);
        report("fence.t time irq pad", e);
        e = errors;
        run_fence_t(1'b1, 1'b1, 1'b1);
        report("fence.t priv exit pad", e);
        e = errors;
        run_fence_t(1'b1, 1'b0, 1'b0);
        report("fence.t ignored time irq", e);

        $display("Checks: %0d run, %0d wrong", checks, errors);
        if (errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

/* flush_ctrl_top.f */
rtl/isa_pkg.sv
rtl/flush_pkg.sv
rtl/updown_counter.sv
rtl/flush_decode.sv
rtl/fence_t_seq.sv
rtl/ctrl_merge.sv
rtl/flush_ctrl_top.sv
dv/flush_ctrl_assertions.sv
dv/flush_ctrl_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build the flush controller testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module flush_ctrl_tb \
    -f flush_ctrl_top.f \
    -o flush_ctrl_sim

./obj_dir/flush_ctrl_sim | tee sim.log

if grep -q "ALL CHECKS PASSED" sim.log; then
    echo "Simulation passed"
    exit 0
else
    echo "Simulation failed"
    exit 1
fi
